//--- mem_pkg.sv
`default_nettype none

package mem_pkg;

   // written word and returned byte
   localparam int WR_DATA_W = 32;
   localparam int RD_DATA_W = 8;

   // bytes per word, one narrow bank per byte lane
   localparam int BANKS = WR_DATA_W / RD_DATA_W;

   // 16 words deep, seen as 64 bytes from the read side
   localparam int WR_ADDR_W = 4;
   localparam int RD_ADDR_W = 6;

   // byte-address bits below the word address
   localparam int LANE_SEL_W = RD_ADDR_W - WR_ADDR_W;

   typedef logic [WR_DATA_W-1:0] wr_word_t;
   typedef logic [RD_DATA_W-1:0] rd_word_t;

   typedef logic [WR_ADDR_W-1:0] wr_addr_t;
   typedef logic [RD_ADDR_W-1:0] rd_addr_t;

endpackage

`default_nettype wire

//--- fifo_pkg.sv
`default_nettype none

package fifo_pkg;

   // pointers carry one wrap bit above the address
   typedef logic [mem_pkg::WR_ADDR_W:0] wr_ptr_t;
   typedef logic [mem_pkg::RD_ADDR_W:0] rd_ptr_t;

   // full once less than a whole word of bytes is free
   localparam int FULL_LEVEL = (2 ** mem_pkg::RD_ADDR_W) - mem_pkg::BANKS;

   typedef struct packed {
      logic              en;
      mem_pkg::wr_addr_t addr;
      mem_pkg::wr_word_t data;
   } wr_req_t;

   typedef struct packed {
      logic              en;
      mem_pkg::rd_addr_t addr;
   } rd_req_t;

endpackage

`default_nettype wire

//--- bank_ram.sv
`timescale 1ns/10ps
`default_nettype none

module bank_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk,
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // output register holds between reads
   always_ff @(posedge clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

//--- asym_ram.sv
`timescale 1ns/10ps
`default_nettype none

module asym_ram #(
   parameter int W_DATA_W = mem_pkg::WR_DATA_W,
   parameter int W_ADDR_W = mem_pkg::WR_ADDR_W,
   parameter int R_DATA_W = mem_pkg::RD_DATA_W,
   parameter int R_ADDR_W = mem_pkg::RD_ADDR_W
) (
   input  logic              clk,
   input  fifo_pkg::wr_req_t wr_req,
   input  fifo_pkg::rd_req_t rd_req,
   output mem_pkg::rd_word_t rd_data
);

   // narrow side sets the bank width, wide side the bank count
   localparam int MAX_W       = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_W       = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int N           = MAX_W / MIN_W;
   localparam int MAX_ADDR_W  = (W_ADDR_W > R_ADDR_W) ? W_ADDR_W : R_ADDR_W;
   localparam int BANK_ADDR_W = (W_ADDR_W > R_ADDR_W) ? R_ADDR_W : W_ADDR_W;
   localparam int SEL_W       = (N > 1) ? $clog2(N) : 1;

   logic [W_DATA_W-1:0]    w_data;
   logic [W_ADDR_W-1:0]    w_addr;
   logic [R_ADDR_W-1:0]    r_addr;
   logic [R_DATA_W-1:0]    r_data;

   logic [N-1:0]           bank_we;
   logic [BANK_ADDR_W-1:0] bank_wa;
   logic [BANK_ADDR_W-1:0] bank_ra;
   logic [MIN_W-1:0]       bank_wd [N];
   logic [MIN_W-1:0]       bank_rd [N];

   assign w_data  = wr_req.data;
   assign w_addr  = wr_req.addr;
   assign r_addr  = rd_req.addr;
   assign rd_data = r_data;

   for (genvar i = 0; i < N; i++) begin : g_bank
      bank_ram #(
         .DATA_W (MIN_W),
         .ADDR_W (BANK_ADDR_W)
      ) u_bank (
         .clk    (clk),
         .w_en   (bank_we[i]),
         .w_addr (bank_wa),
         .w_data (bank_wd[i]),
         .r_en   (rd_req.en),
         .r_addr (bank_ra),
         .r_data (bank_rd[i])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wr_wide
      logic [SEL_W-1:0] sel_q;

      // every bank takes its own lane of the word
      assign bank_wa = w_addr;
      assign bank_ra = r_addr[R_ADDR_W-1 -: BANK_ADDR_W];

      always_comb begin
         for (int j = 0; j < N; j++) begin
            bank_we[j] = wr_req.en;
            bank_wd[j] = w_data[j*MIN_W +: MIN_W];
         end
      end

      // lane select lines up with the registered bank output
      always_ff @(posedge clk) begin
         if (rd_req.en) begin
            sel_q <= r_addr[SEL_W-1:0];
         end
      end

      assign r_data = bank_rd[sel_q];
   end else if (W_DATA_W < R_DATA_W) begin : g_rd_wide
      // low write address bits pick the one bank to update
      assign bank_wa = w_addr[W_ADDR_W-1 -: BANK_ADDR_W];
      assign bank_ra = r_addr;

      always_comb begin
         for (int j = 0; j < N; j++) begin
            bank_we[j] = wr_req.en && (w_addr[SEL_W-1:0] == SEL_W'(j));
            bank_wd[j] = w_data;
         end
      end

      always_comb begin
         for (int j = 0; j < N; j++) begin
            r_data[j*MIN_W +: MIN_W] = bank_rd[j];
         end
      end
   end else begin : g_same
      assign bank_we    = wr_req.en;
      assign bank_wa    = w_addr;
      assign bank_ra    = r_addr;
      assign bank_wd[0] = w_data;
      assign r_data     = bank_rd[0];
   end

   // whole banks only, and the spare address bits cover the lane select
   a_geometry : assert property (@(posedge clk)
      ((MAX_W % MIN_W) == 0) && ((N == 1) || ((MAX_ADDR_W - BANK_ADDR_W) == SEL_W)));

endmodule

`default_nettype wire

//--- fifo_wr_side.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_wr_side (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wr_en,
   input  mem_pkg::wr_word_t wr_data,
   input  fifo_pkg::rd_ptr_t rd_ptr,
   output fifo_pkg::wr_ptr_t wr_ptr,
   output logic              full,
   output fifo_pkg::wr_req_t wr_req
);

   fifo_pkg::rd_ptr_t wr_bytes;
   fifo_pkg::rd_ptr_t occupancy;
   logic              wr_accept;

   // word pointer scaled to bytes, wraps with the byte pointer
   assign wr_bytes  = {wr_ptr, {mem_pkg::LANE_SEL_W{1'b0}}};
   assign occupancy = wr_bytes - rd_ptr;

   assign full      = occupancy > fifo_pkg::rd_ptr_t'(fifo_pkg::FULL_LEVEL);
   assign wr_accept = wr_en && !full;

   assign wr_req.en   = wr_accept;
   assign wr_req.addr = wr_ptr[mem_pkg::WR_ADDR_W-1:0];
   assign wr_req.data = wr_data;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (wr_accept) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
   end

   // a write while full is dropped
   a_no_write_when_full : assert property (@(posedge clk) disable iff (!rst_n)
      full |=> $stable(wr_ptr));

endmodule

`default_nettype wire

//--- fifo_rd_side.sv
`timescale 1ns/10ps
`default_nettype none

module fifo_rd_side (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rd_en,
   input  fifo_pkg::wr_ptr_t wr_ptr,
   output fifo_pkg::rd_ptr_t rd_ptr,
   output logic              empty,
   output fifo_pkg::rd_req_t rd_req,
   output logic              rd_valid
);

   fifo_pkg::rd_ptr_t wr_bytes;
   logic              rd_accept;

   // byte view of the write pointer
   assign wr_bytes = {wr_ptr, {mem_pkg::LANE_SEL_W{1'b0}}};

   assign empty     = (wr_bytes == rd_ptr);
   assign rd_accept = rd_en && !empty;

   assign rd_req.en   = rd_accept;
   assign rd_req.addr = rd_ptr[mem_pkg::RD_ADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr   <= '0;
         rd_valid <= 1'b0;
      end else begin
         // pulse lines up with the registered RAM output
         rd_valid <= rd_accept;
         if (rd_accept) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // data only follows a byte the pointer has just stepped past
   a_valid_after_read : assert property (@(posedge clk) disable iff (!rst_n)
      rd_valid |-> (rd_ptr == $past(rd_ptr) + 1'b1));

   // reads while empty leave the pointer alone
   a_no_read_when_empty : assert property (@(posedge clk) disable iff (!rst_n)
      empty |=> $stable(rd_ptr));

endmodule

`default_nettype wire

//--- asym_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module asym_fifo (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wr_en,
   input  mem_pkg::wr_word_t wr_data,
   output logic              full,
   input  logic              rd_en,
   output mem_pkg::rd_word_t rd_data,
   output logic              rd_valid,
   output logic              empty
);

   fifo_pkg::wr_ptr_t wr_ptr;
   fifo_pkg::rd_ptr_t rd_ptr;
   fifo_pkg::wr_req_t wr_req;
   fifo_pkg::rd_req_t rd_req;

   fifo_wr_side u_wr_side (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rd_ptr  (rd_ptr),
      .wr_ptr  (wr_ptr),
      .full    (full),
      .wr_req  (wr_req)
   );

   fifo_rd_side u_rd_side (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_en    (rd_en),
      .wr_ptr   (wr_ptr),
      .rd_ptr   (rd_ptr),
      .empty    (empty),
      .rd_req   (rd_req),
      .rd_valid (rd_valid)
   );

   // word-wide writes, byte-wide reads
   asym_ram #(
      .W_DATA_W (mem_pkg::WR_DATA_W),
      .W_ADDR_W (mem_pkg::WR_ADDR_W),
      .R_DATA_W (mem_pkg::RD_DATA_W),
      .R_ADDR_W (mem_pkg::RD_ADDR_W)
   ) u_ram (
      .clk     (clk),
      .wr_req  (wr_req),
      .rd_req  (rd_req),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

//--- tb_asym_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module tb_asym_fifo;

   localparam int WAIT_LIMIT    = 16;
   localparam int RANDOM_CYCLES = 400;
   // full once more than 60 bytes are held
   localparam int FULL_BYTES    = 60;

   logic              clk;
   logic              rst_n;
   logic              wr_en;
   mem_pkg::wr_word_t wr_data;
   logic              full;
   logic              rd_en;
   mem_pkg::rd_word_t rd_data;
   logic              rd_valid;
   logic              empty;

   // bytes accepted by the FIFO and not yet delivered, oldest first
   logic [7:0] ref_q [$];

   int error_count;
   int tests_passed;
   int tests_failed;

   asym_fifo UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .full     (full),
      .rd_en    (rd_en),
      .rd_data  (rd_data),
      .rd_valid (rd_valid),
      .empty    (empty)
   );

   always #10 clk = ~clk;

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
         error_count++;
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         $display("test %s: ok", name);
         tests_passed++;
      end else begin
         $display("test %s: FAILED with %0d errors", name, error_count - errors_before);
         tests_failed++;
      end
   endtask

   // lowest byte leaves first
   task automatic push_word(input mem_pkg::wr_word_t word);
      for (int b = 0; b < 4; b++) begin
         ref_q.push_back(word[b*8 +: 8]);
      end
   endtask

   task automatic compare_byte();
      if (ref_q.size() == 0) begin
         $display("rd_valid came with no byte left in the reference queue");
         error_count++;
      end else begin
         check("rd_data", rd_data, ref_q.pop_front());
      end
   endtask

   // called on a falling edge, returns on the falling edge after the write edge
   task automatic write_word(input mem_pkg::wr_word_t word);
      wr_en   = 1'b1;
      wr_data = word;
      if (!full) begin
         push_word(word);
      end
      @(negedge clk);
      wr_en = 1'b0;
   endtask

   task automatic read_byte();
      int waited;
      rd_en = 1'b1;
      @(negedge clk);
      rd_en  = 1'b0;
      waited = 1;
      while (!rd_valid && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!rd_valid) begin
         $display("timeout waiting for rd_valid after a read request");
         error_count++;
      end else begin
         check("rd_valid latency", waited, 1);
         compare_byte();
      end
   endtask

   task automatic test_reset();
      int errors_before;
      errors_before = error_count;
      check("empty", empty, 1);
      check("full", full, 0);
      check("rd_valid", rd_valid, 0);
      report_test("reset state", errors_before);
   endtask

   task automatic test_byte_order();
      int errors_before;
      errors_before = error_count;
      write_word(32'ha1b2c3d4);
      check("empty", empty, 0);
      for (int i = 0; i < 4; i++) begin
         read_byte();
      end
      @(negedge clk);
      check("rd_valid", rd_valid, 0);
      check("empty", empty, 1);
      check("reference queue size", ref_q.size(), 0);
      report_test("byte order", errors_before);
   endtask

   task automatic test_fill_overflow();
      int errors_before;
      errors_before = error_count;
      // bytes 0x00 to 0x3f in delivery order
      for (int i = 0; i < 16; i++) begin
         write_word(32'h03020100 + 32'h04040404 * i);
         if (i == 14) begin
            check("full", full, 0);
         end
      end
      check("full", full, 1);
      write_word(32'hffeeddcc);
      check("full", full, 1);
      for (int i = 0; i < 64; i++) begin
         read_byte();
      end
      @(negedge clk);
      check("empty", empty, 1);
      check("reference queue size", ref_q.size(), 0);
      report_test("fill and overflow", errors_before);
   endtask

   task automatic test_underflow();
      int errors_before;
      errors_before = error_count;
      rd_en = 1'b1;
      for (int i = 0; i < 6; i++) begin
         @(negedge clk);
         check("rd_valid", rd_valid, 0);
         check("empty", empty, 1);
      end
      rd_en = 1'b0;
      @(negedge clk);
      check("rd_valid", rd_valid, 0);
      report_test("underflow", errors_before);
   endtask

   task automatic test_random();
      int   errors_before;
      int   occupancy;
      int   reads;
      logic wr_take;
      logic rd_take;
      errors_before = error_count;
      occupancy     = 0;
      for (int cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
         if (rd_valid) begin
            compare_byte();
         end
         check("full", full, occupancy > FULL_BYTES);
         check("empty", empty, occupancy == 0);
         // lean towards filling first, then towards draining
         if (cycle < RANDOM_CYCLES / 2) begin
            wr_en = ($urandom % 4) != 0;
            rd_en = ($urandom % 2) != 0;
         end else begin
            wr_en = ($urandom % 16) == 0;
            rd_en = ($urandom % 4) != 0;
         end
         wr_data = $urandom;
         wr_take = wr_en && !full;
         rd_take = rd_en && !empty;
         if (wr_take) begin
            push_word(wr_data);
         end
         occupancy = occupancy + (wr_take ? 4 : 0) - (rd_take ? 1 : 0);
         @(negedge clk);
      end
      wr_en = 1'b0;
      rd_en = 1'b0;
      if (rd_valid) begin
         compare_byte();
      end
      reads = 0;
      while (!empty && reads < 64 + WAIT_LIMIT) begin
         read_byte();
         reads++;
      end
      if (!empty) begin
         $display("FIFO still not empty after draining the random traffic");
         error_count++;
      end
      @(negedge clk);
      check("reference queue size", ref_q.size(), 0);
      report_test("random traffic and flags", errors_before);
   endtask

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      wr_en        = 1'b0;
      wr_data      = '0;
      rd_en        = 1'b0;
      error_count  = 0;
      tests_passed = 0;
      tests_failed = 0;
      void'($urandom(43));

      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      test_reset();
      test_byte_order();
      test_fill_overflow();
      test_underflow();
      test_random();

      $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
               tests_passed, tests_failed, error_count);
      if (tests_failed == 0 && error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
mem_pkg.sv
fifo_pkg.sv
bank_ram.sv
asym_ram.sv
fifo_wr_side.sv
fifo_rd_side.sv
asym_fifo.sv
tb_asym_fifo.sv

//--- run_sim.sh
#!/bin/sh
# builds the asym_fifo testbench with Verilator, runs it and scans the log

top=tb_asym_fifo
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$top" -f files.f -o "V$top"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./obj_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if [ ! -s "$log" ]; then
   echo "simulation log is missing or empty"
   exit 1
fi

# the testbench prints its verdict into the log
if grep -q "Some tests failed" "$log"; then
   echo "simulation: FAIL"
   exit 1
fi

echo "simulation: PASS"
exit 0
